// ==== ddr_read_datapath.f ====
source/read_datapath_pkg.sv
source/read_latency_ctrl.sv
source/read_resync_fifo.sv
source/oct_window.sv
source/read_datapath.sv
testbench/read_datapath_checker.sv
testbench/tb_read_datapath.sv

// ==== testbench/tb_read_datapath.sv ====
// Testbench top for the AFI read datapath
// Clock, reset, LFSR stimulus, read schedules, watchdog and the DUT
`timescale 1ns/1ps
`default_nettype none

module tb_read_datapath;

	import read_datapath_pkg::*;

	localparam logic [31:0] LFSR_SEED = 32'h90ed201a;
	localparam logic [31:0] LFSR_TAPS = 32'ha3000000;
	localparam int NUM_TESTS = 5;
	localparam int SCHED_LEN = 512;

	logic pll_afi_clk;
	logic reset_n_afi_clk;
	ddio_dq_t ddio_phy_dq_i;
	logic [NUM_DQS_GROUPS-1:0] read_capture_clk_i;
	logic afi_rdata_en_full_i;
	latency_count_t seq_read_latency_counter_i;
	logic [NUM_DQS_GROUPS-1:0] seq_read_fifo_reset_i;
	afi_rdata_t afi_rdata_o;
	logic afi_rdata_valid_o;
	logic force_oct_off_o;
	int error_count;
	logic [31:0] lfsr_state;
	int latency;
	int round;

	read_datapath u_dut (
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.ddio_phy_dq_i              (ddio_phy_dq_i),
		.read_capture_clk_i         (read_capture_clk_i),
		.afi_rdata_en_full_i        (afi_rdata_en_full_i),
		.seq_read_latency_counter_i (seq_read_latency_counter_i),
		.seq_read_fifo_reset_i      (seq_read_fifo_reset_i),
		.afi_rdata_o                (afi_rdata_o),
		.afi_rdata_valid_o          (afi_rdata_valid_o),
		.force_oct_off_o            (force_oct_off_o)
	);

	read_datapath_checker u_checker (
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.ddio_phy_dq_i              (ddio_phy_dq_i),
		.read_capture_clk_i         (read_capture_clk_i),
		.afi_rdata_en_full_i        (afi_rdata_en_full_i),
		.seq_read_latency_counter_i (seq_read_latency_counter_i),
		.seq_read_fifo_reset_i      (seq_read_fifo_reset_i),
		.afi_rdata_i                (afi_rdata_o),
		.afi_rdata_valid_i          (afi_rdata_valid_o),
		.force_oct_off_i            (force_oct_off_o),
		.error_count_o              (error_count)
	);

	initial
		pll_afi_clk = 1'b0;

	always #10 pll_afi_clk = ~pll_afi_clk;

	// ************************************************************
	// Random source and stimulus tasks
	// ************************************************************

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
	endfunction

	// One LFSR step for every bit handed out
	task automatic take_random(input int nbits, output logic [31:0] value);
		int i;
		value = '0;
		for (i = 0; i < nbits; i++)
		begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	task automatic pick_latency();
		logic [31:0] rnd;
		take_random(4, rnd);
		latency = int'(rnd) + 1;
		@(posedge pll_afi_clk);
		#2;
		seq_read_latency_counter_i = latency_count_t'(latency);
	endtask

	// Called 2 ns after an edge, strobes rise at 5 ns and 7 ns and fall before the next edge
	task automatic capture_beat();
		logic [31:0] rnd;
		take_random(32, rnd);
		ddio_phy_dq_i = rnd;
		#3;
		read_capture_clk_i[0] = 1'b1;
		#2;
		read_capture_clk_i[1] = 1'b1;
		#3;
		read_capture_clk_i[0] = 1'b0;
		#2;
		read_capture_clk_i[1] = 1'b0;
	endtask

	// Enables land on edge E, each word is captured after edge E+L-2
	task automatic run_reads(input int n_reads, input int gap_mask);
		logic en_at [SCHED_LEN];
		logic cap_at [SCHED_LEN];
		logic [31:0] rnd;
		int edge_e;
		int last;
		int k;
		int t;
		for (t = 0; t < SCHED_LEN; t++)
		begin
			en_at[t] = 1'b0;
			cap_at[t] = 1'b0;
		end
		edge_e = latency + 2;
		last = edge_e;
		for (k = 0; k < n_reads; k++)
		begin
			en_at[edge_e-1] = 1'b1;
			cap_at[edge_e+latency-2] = 1'b1;
			last = edge_e;
			take_random(3, rnd);
			edge_e = edge_e + 1 + (int'(rnd) & gap_mask);
		end
		// The tail lets every valid and OCT window drain before the latency changes
		for (t = 0; t <= last + MAX_READ_LATENCY + 4; t++)
		begin
			@(posedge pll_afi_clk);
			#2;
			afi_rdata_en_full_i = en_at[t];
			if (cap_at[t])
				capture_beat();
		end
	endtask

	// ************************************************************
	// Test sequence
	// ************************************************************

	initial
	begin
		lfsr_state = LFSR_SEED;
		latency = 1;
		reset_n_afi_clk = 1'b0;
		ddio_phy_dq_i = '0;
		read_capture_clk_i = '0;
		afi_rdata_en_full_i = 1'b0;
		seq_read_latency_counter_i = latency_count_t'(1);
		seq_read_fifo_reset_i = '0;
		repeat (10) @(posedge pll_afi_clk);
		#2;
		reset_n_afi_clk = 1'b1;

		repeat (24) @(posedge pll_afi_clk);
		u_checker.report_test("reset_idle");

		// First round runs back to back, the rest leave small gaps
		for (round = 0; round < 3; round++)
		begin
			pick_latency();
			run_reads(6, (round == 0) ? 0 : 1);
		end
		u_checker.report_test("latency");

		pick_latency();
		run_reads(24, 3);
		u_checker.report_test("data_order");

		// Gaps up to 7 cycles give both merged and separate windows
		pick_latency();
		run_reads(12, 7);
		u_checker.report_test("oct_window");

		// Stray words are captured and then discarded by the FIFO reset
		pick_latency();
		repeat (3)
		begin
			@(posedge pll_afi_clk);
			#2;
			capture_beat();
		end
		@(posedge pll_afi_clk);
		#2;
		seq_read_fifo_reset_i = '1;
		@(posedge pll_afi_clk);
		#2;
		seq_read_fifo_reset_i = '0;
		repeat (3) @(posedge pll_afi_clk);
		run_reads(3, 1);
		u_checker.report_test("fifo_reset");

		repeat (2) @(posedge pll_afi_clk);
		u_checker.report_totals();
		if (error_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// Budget of 200 cycles per test plus startup
	initial
	begin
		repeat (NUM_TESTS * 200 + 100) @(posedge pll_afi_clk);
		$display("Watchdog expired before all tests finished");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/read_datapath_checker.sv ====
// Checker for the AFI read datapath
// Records captured words, runs the reference model and compares on every clock
`timescale 1ns/1ps
`default_nettype none

module read_datapath_checker (
	input wire pll_afi_clk,
	input wire reset_n_afi_clk,
	input wire read_datapath_pkg::ddio_dq_t ddio_phy_dq_i,
	input wire [read_datapath_pkg::NUM_DQS_GROUPS-1:0] read_capture_clk_i,
	input wire afi_rdata_en_full_i,
	input wire read_datapath_pkg::latency_count_t seq_read_latency_counter_i,
	input wire [read_datapath_pkg::NUM_DQS_GROUPS-1:0] seq_read_fifo_reset_i,
	input wire read_datapath_pkg::afi_rdata_t afi_rdata_i,
	input wire afi_rdata_valid_i,
	input wire force_oct_off_i,
	output int error_count_o
);

	import read_datapath_pkg::*;

	// Enable history deep enough for the largest latency plus margin
	localparam int HIST_DEPTH = 32;

	// Termination is on from 3 to 8 cycles after each enable
	localparam int OCT_WINDOW_FIRST = 3;
	localparam int OCT_WINDOW_LAST = 8;

	typedef struct packed {
		afi_rdata_t rdata;
		logic valid;
		logic oct_off;
	} expect_t;

	// Bit j is the enable that was sampled j edges before the latest one
	logic [HIST_DEPTH-1:0] en_hist;
	logic seen_edge;
	logic last_valid;
	group_beats_t pushed_q0[$];
	group_beats_t pushed_q1[$];
	group_beats_t front0;
	group_beats_t front1;
	expect_t expected;
	int total_checks;
	int total_errors;
	int test_checks;
	int test_errors;
	int tests_run;
	int tests_failed;

	assign error_count_o = total_errors;

	initial
	begin
		en_hist = '0;
		seen_edge = 1'b0;
		last_valid = 1'b0;
		total_checks = 0;
		total_errors = 0;
		test_checks = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
	end

	// ************************************************************
	// Reference model
	// ************************************************************

	// Expected outputs after an edge, from the enable history and the oldest words
	function automatic expect_t predict_outputs(input logic [HIST_DEPTH-1:0] hist,
		input int lat, input group_beats_t oldest1, input group_beats_t oldest0);
		expect_t e;
		int k;
		// Valid follows the enable from exactly lat edges earlier
		e.valid = (lat >= 1 && lat <= MAX_READ_LATENCY) ? hist[lat] : 1'b0;
		e.oct_off = 1'b1;
		for (k = OCT_WINDOW_FIRST; k <= OCT_WINDOW_LAST; k++)
		begin
			if (hist[k])
				e.oct_off = 1'b0;
		end
		// AFI order is time slot first, group 1 above group 0 in each slot
		e.rdata = {oldest1.slot1, oldest0.slot1, oldest1.slot0, oldest0.slot0};
		return e;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp_value,
		input logic [31:0] act_value);
		total_checks++;
		test_checks++;
		if (act_value !== exp_value)
		begin
			total_errors++;
			test_errors++;
			$display("CHECK FAILED %s expected 0x%0h got 0x%0h at %0t",
				name, exp_value, act_value, $time);
		end
	endtask

	// ************************************************************
	// History tracking
	// ************************************************************

	// Each strobe edge pushes the word on the DDIO bus for that group
	always @(posedge read_capture_clk_i[0])
	begin
		if (reset_n_afi_clk)
			pushed_q0.push_back(ddio_phy_dq_i.group[0]);
	end

	always @(posedge read_capture_clk_i[1])
	begin
		if (reset_n_afi_clk)
			pushed_q1.push_back(ddio_phy_dq_i.group[1]);
	end

	always @(posedge pll_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			en_hist = '0;
			seen_edge = 1'b0;
			last_valid = 1'b0;
			pushed_q0.delete();
			pushed_q1.delete();
		end
		else
		begin
			// A valid cycle that just ended pops one word from each group
			if (last_valid && pushed_q0.size() > 0)
				void'(pushed_q0.pop_front());
			if (last_valid && pushed_q1.size() > 0)
				void'(pushed_q1.pop_front());
			// The sequencer's FIFO reset throws away every unread word
			if (seq_read_fifo_reset_i[0])
				pushed_q0.delete();
			if (seq_read_fifo_reset_i[1])
				pushed_q1.delete();
			en_hist = {en_hist[HIST_DEPTH-2:0], afi_rdata_en_full_i};
			seen_edge = 1'b1;
		end
	end

	// ************************************************************
	// Compare, mid cycle where all outputs are settled
	// ************************************************************

	always @(negedge pll_afi_clk)
	begin
		if (reset_n_afi_clk && seen_edge)
		begin
			front0 = (pushed_q0.size() > 0) ? pushed_q0[0] : '0;
			front1 = (pushed_q1.size() > 0) ? pushed_q1[0] : '0;
			expected = predict_outputs(en_hist, int'(seq_read_latency_counter_i),
				front1, front0);
			check_value("afi_rdata_valid_o", 32'(expected.valid), 32'(afi_rdata_valid_i));
			check_value("force_oct_off_o", 32'(expected.oct_off), 32'(force_oct_off_i));
			if (expected.valid)
			begin
				if (pushed_q0.size() == 0 || pushed_q1.size() == 0)
				begin
					total_errors++;
					test_errors++;
					$display("A read was due at %0t but no word had been captured", $time);
				end
				else
					check_value("afi_rdata_o", expected.rdata, afi_rdata_i);
			end
			last_valid = expected.valid;
		end
	end

	// ************************************************************
	// Reporting
	// ************************************************************

	task automatic report_test(input string name);
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("test %-12s %0d checks, %0d errors, %s", name, test_checks, test_errors,
			(test_errors == 0) ? "ok" : "failed");
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic report_totals();
		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, total_checks, total_errors);
	endtask

endmodule

`default_nettype wire

// ==== source/read_datapath.sv ====
// Top level of the AFI read datapath
// Latency control, one resynchronization FIFO per DQS group and the OCT window
`timescale 1ns/1ps
`default_nettype none

module read_datapath (
	input wire pll_afi_clk,
	input wire reset_n_afi_clk,
	input wire read_datapath_pkg::ddio_dq_t ddio_phy_dq_i,
	input wire [read_datapath_pkg::NUM_DQS_GROUPS-1:0] read_capture_clk_i,
	input wire afi_rdata_en_full_i,
	input wire read_datapath_pkg::latency_count_t seq_read_latency_counter_i,
	input wire [read_datapath_pkg::NUM_DQS_GROUPS-1:0] seq_read_fifo_reset_i,
	output read_datapath_pkg::afi_rdata_t afi_rdata_o,
	output logic afi_rdata_valid_o,
	output logic force_oct_off_o
);

	import read_datapath_pkg::*;

	// One read strobe for all groups, every FIFO pops in the same cycle
	logic read_enable;

	read_latency_ctrl u_latency_ctrl (
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.afi_rdata_en_full_i        (afi_rdata_en_full_i),
		.seq_read_latency_counter_i (seq_read_latency_counter_i),
		.read_enable_o              (read_enable),
		.afi_rdata_valid_o          (afi_rdata_valid_o)
	);

	// ************************************************************
	// Per-group resynchronization and reordering
	// ************************************************************

	genvar g;
	generate
		for (g = 0; g < NUM_DQS_GROUPS; g++)
		begin : g_group
			group_beats_t fifo_q;

			// Each group is captured on its own strobe
			read_resync_fifo u_fifo (
				.pll_afi_clk           (pll_afi_clk),
				.reset_n_afi_clk       (reset_n_afi_clk),
				.read_capture_clk_i    (read_capture_clk_i[g]),
				.capture_data_i        (ddio_phy_dq_i.group[g]),
				.seq_read_fifo_reset_i (seq_read_fifo_reset_i[g]),
				.read_enable_i         (read_enable),
				.read_data_o           (fifo_q)
			);

			// The FIFO hands back slot 1 and slot 0 of this group
			// Scatter them into the matching group lane of each AFI time slot
			assign afi_rdata_o.slot1[g] = fifo_q.slot1;
			assign afi_rdata_o.slot0[g] = fifo_q.slot0;
		end
	endgenerate

	// Termination follows the raw enable, not the tuned latency
	oct_window u_oct (
		.pll_afi_clk         (pll_afi_clk),
		.reset_n_afi_clk     (reset_n_afi_clk),
		.afi_rdata_en_full_i (afi_rdata_en_full_i),
		.force_oct_off_o     (force_oct_off_o)
	);

endmodule

`default_nettype wire

// ==== source/oct_window.sv ====
// On-die termination window around each read
// Keeps the read enable history and drives force_oct_off
`timescale 1ns/1ps
`default_nettype none

module oct_window (
	input wire pll_afi_clk,
	input wire reset_n_afi_clk,
	input wire afi_rdata_en_full_i,
	output logic force_oct_off_o
);

	import read_datapath_pkg::*;

	// Bit k-1 holds the enable that was sampled k edges ago
	logic [OCT_OFF_DELAY-1:0] rdata_en_r;

	// History with the current enable in front
	// Bit k of this vector is the enable from k edges before the current one
	logic [OCT_OFF_DELAY:0] rdata_en_shifter;

	// Any enable inside the window turns termination on
	logic read_in_window;

	assign rdata_en_shifter = {rdata_en_r, afi_rdata_en_full_i};
	assign read_in_window = |rdata_en_shifter[OCT_OFF_DELAY:OCT_ON_DELAY];

	// ************************************************************
	// Window register
	// ************************************************************

	// Termination is switched off by default
	// During reset the output holds low and the first edge after release sets it
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rdata_en_r <= '0;
			force_oct_off_o <= 1'b0;
		end
		else
		begin
			rdata_en_r <= rdata_en_shifter[OCT_OFF_DELAY-1:0];
			// Close reads simply stretch the window, the ranges merge
			force_oct_off_o <= ~read_in_window;
		end
	end

endmodule

`default_nettype wire

// ==== source/read_resync_fifo.sv ====
// Read resynchronization FIFO for one DQS group
// Written on the capture strobe, read on the AFI clock, with its write-side reset
`timescale 1ns/1ps
`default_nettype none

module read_resync_fifo (
	input wire pll_afi_clk,
	input wire reset_n_afi_clk,
	input wire read_capture_clk_i,
	input wire read_datapath_pkg::group_beats_t capture_data_i,
	input wire seq_read_fifo_reset_i,
	input wire read_enable_i,
	output read_datapath_pkg::group_beats_t read_data_o
);

	import read_datapath_pkg::*;

	// Register storage, one entry per strobe edge
	group_beats_t mem [READ_FIFO_DEPTH];

	// Write pointer lives in the strobe domain
	logic [READ_FIFO_ADDR_WIDTH-1:0] wr_ptr;

	// Read pointer lives in the AFI domain
	logic [READ_FIFO_ADDR_WIDTH-1:0] rd_ptr;

	// Active low reset for the write side, launched from pll_afi_clk
	logic reset_n_fifo_wr;

	// ************************************************************
	// Write side reset
	// ************************************************************

	// System reset and the sequencer FIFO reset both clear the write side
	// The sequencer only releases its reset while the strobe is idle
	// so the pointer leaves reset with no strobe edge near the release
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			reset_n_fifo_wr <= 1'b0;
		end
		else
		begin
			reset_n_fifo_wr <= ~seq_read_fifo_reset_i;
		end
	end

	// ************************************************************
	// Write side, capture strobe domain
	// ************************************************************

	// The strobe only toggles during a burst
	// Every rising edge therefore carries one word and no write enable is needed
	always_ff @(posedge read_capture_clk_i or negedge reset_n_fifo_wr)
	begin
		if (!reset_n_fifo_wr)
		begin
			wr_ptr <= '0;
		end
		else
		begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge read_capture_clk_i)
	begin
		mem[wr_ptr] <= capture_data_i;
	end

	// ************************************************************
	// Read side, AFI clock domain
	// ************************************************************

	// The sequencer reset is already synchronous to pll_afi_clk here
	// Depth is a power of two, so the pointer wraps on its own
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rd_ptr <= '0;
		end
		else if (seq_read_fifo_reset_i)
		begin
			rd_ptr <= '0;
		end
		else if (read_enable_i)
		begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Oldest unread entry is always presented, the pop just advances past it
	// The latency setting keeps this entry stable long before it is read
	assign read_data_o = mem[rd_ptr];

endmodule

`default_nettype wire

// ==== source/read_latency_ctrl.sv ====
// Read latency control with the enable shift register and tap select
// Produces the FIFO read enable and the AFI read valid
`timescale 1ns/1ps
`default_nettype none

module read_latency_ctrl (
	input wire pll_afi_clk,
	input wire reset_n_afi_clk,
	input wire afi_rdata_en_full_i,
	input wire read_datapath_pkg::latency_count_t seq_read_latency_counter_i,
	output logic read_enable_o,
	output logic afi_rdata_valid_o
);

	import read_datapath_pkg::*;

	// Stage k holds the enable that was sampled k+1 edges ago
	logic [MAX_READ_LATENCY-1:0] latency_shifter;

	// The latency count is one based, the stage index is zero based
	latency_count_t lat_minus_one;
	logic [$clog2(MAX_READ_LATENCY)-1:0] tap_sel;
	logic tap_in_range;
	logic tap_out;

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			latency_shifter <= '0;
		end
		else
		begin
			latency_shifter <= {latency_shifter[MAX_READ_LATENCY-2:0], afi_rdata_en_full_i};
		end
	end

	// ************************************************************
	// Tap select
	// ************************************************************

	assign lat_minus_one = seq_read_latency_counter_i - latency_count_t'(1);
	assign tap_sel = lat_minus_one[$clog2(MAX_READ_LATENCY)-1:0];

	// A count of zero wraps around, so it lands out of range as well
	// Out of range counts never raise a read
	assign tap_in_range = (lat_minus_one < MAX_READ_LATENCY);
	assign tap_out = tap_in_range && latency_shifter[tap_sel];

	// The selected tap costs one more register stage
	// That stage completes the L cycle latency from enable to valid
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			read_enable_o <= 1'b0;
			afi_rdata_valid_o <= 1'b0;
		end
		else
		begin
			// Read enable pops the FIFOs and valid goes out to the controller
			// Both carry the same registered tap
			read_enable_o <= tap_out;
			afi_rdata_valid_o <= tap_out;
		end
	end

endmodule

`default_nettype wire

// ==== source/read_datapath_pkg.sv ====
// Shared constants and packed data types of the DDR3 AFI read datapath
// Geometry, latency and on-die termination timing, plus the DQ word layouts
`default_nettype none

package read_datapath_pkg;

	// ************************************************************
	// Geometry
	// ************************************************************

	// Two read DQS groups share the DQ bus evenly
	localparam int NUM_DQS_GROUPS = 2;
	localparam int MEM_DQ_WIDTH = 16;
	localparam int DQ_GROUP_WIDTH = MEM_DQ_WIDTH / NUM_DQS_GROUPS;

	// Full rate gives one rising and one falling beat per AFI cycle
	localparam int NUM_TIMESLOTS = 2;
	localparam int AFI_DATA_WIDTH = MEM_DQ_WIDTH * NUM_TIMESLOTS;

	// ************************************************************
	// Latency and FIFO sizing
	// ************************************************************

	// The latency count selects one of these stages, counts run 1 to 16
	localparam int MAX_READ_LATENCY = 16;
	localparam int LATENCY_COUNT_WIDTH = 5;

	// Depth is a power of two so the pointers simply wrap
	localparam int READ_FIFO_DEPTH = 8;
	localparam int READ_FIFO_ADDR_WIDTH = 3;

	// Memory CAS read latency in memory clock cycles
	localparam int MEM_T_RL = 11;

	// Termination window edges counted in AFI cycles after the read enable
	localparam int OCT_ON_DELAY = (MEM_T_RL > 4) ? ((MEM_T_RL - 4) / 2) : 0;
	localparam int OCT_OFF_DELAY = (MEM_T_RL + 6) / 2;

	// ************************************************************
	// Data layouts
	// ************************************************************

	typedef logic [DQ_GROUP_WIDTH-1:0] dq_group_t;

	// Both beats of one group as they leave the DDIO capture registers
	typedef struct packed {
		dq_group_t slot1;
		dq_group_t slot0;
	} group_beats_t;

	// DDIO output bus, ordered by group first, then by time slot
	typedef struct packed {
		group_beats_t [NUM_DQS_GROUPS-1:0] group;
	} ddio_dq_t;

	// AFI read data, ordered by time slot first, then by group
	typedef struct packed {
		dq_group_t [NUM_DQS_GROUPS-1:0] slot1;
		dq_group_t [NUM_DQS_GROUPS-1:0] slot0;
	} afi_rdata_t;

	typedef logic [LATENCY_COUNT_WIDTH-1:0] latency_count_t;

endpackage

`default_nettype wire
